// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // cpu side
    input  logic                   req_valid,
    input  logic                   req_write,
    input  logic [31:0]            req_addr,
    input  logic [3:0]             req_wstrb,
    input  logic [31:0]            req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [31:0]            resp_rdata,
    output logic                   resp_error,
    input  logic                   fence,
    output logic                   fence_done,
    // tag array
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    input  logic [tag_bits-1:0]    victim_tag,
    input  logic                   sweep_dirty,
    input  logic [tag_bits-1:0]    sweep_tag,
    output logic [index_bits-1:0]  lookup_index,
    output logic [tag_bits-1:0]    lookup_tag,
    output logic                   fill_en,
    output logic                   fill_way,
    output logic                   set_dirty_en,
    output logic                   clean_en,
    output logic [index_bits-1:0]  clean_set,
    output logic                   clean_way,
    output logic                   touch_en,
    output logic [index_bits-1:0]  sweep_index,
    output logic                   sweep_way,
    // data array
    input  logic [31:0]            rd_word_data,
    input  line_t                  rd_line,
    output logic [index_bits-1:0]  rd_set,
    output logic                   rd_way,
    output logic [offset_bits-3:0] req_word,
    output logic                   wr_en,
    output logic                   wr_way,
    output logic [3:0]             wr_strb,
    output logic [31:0]            wr_word_data,
    // memory side
    output logic                   mem_req_valid,
    output logic                   mem_req_write,
    output logic                   mem_req_single,
    output logic [31:0]            mem_addr,
    output line_t                  mem_wdata,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    input  line_t                  mem_resp_data,
    input  logic                   mem_resp_error
);

    localparam logic [3:0] s_idle = 4'd0;
    localparam logic [3:0] s_lookup = 4'd1;
    localparam logic [3:0] s_wb_req = 4'd2;
    localparam logic [3:0] s_wb_wait = 4'd3;
    localparam logic [3:0] s_rf_req = 4'd4;
    localparam logic [3:0] s_rf_wait = 4'd5;
    localparam logic [3:0] s_finish = 4'd6;
    localparam logic [3:0] s_uc_req = 4'd7;
    localparam logic [3:0] s_uc_wait = 4'd8;
    localparam logic [3:0] s_fence = 4'd9;

    logic [3:0]          state;
    logic                fencing;
    logic [index_bits:0] cnt;
    logic                last;
    cache_addr_t         req_a;
    logic                write_q;
    logic                way_q;
    logic                use_uc;
    logic [31:0]         uc_data;
    logic                hit_path;

    function automatic logic [31:0] line_addr(input logic [tag_bits-1:0] tag,
                                              input logic [index_bits-1:0] index);
        cache_addr_t a;
        a.raw = '0;
        a.f.tag = tag;
        a.f.index = index;
        return a.raw;
    endfunction

    assign lookup_index = req_a.f.index;
    assign lookup_tag = req_a.f.tag;
    assign req_word = req_a.f.word;
    assign req_ready = (state == s_idle);
    assign resp_rdata = use_uc ? uc_data : rd_word_data;

    // sweep counter walks set then way
    assign last = &cnt;
    assign sweep_index = cnt[index_bits:1];
    assign sweep_way = cnt[0];

    // finish reuses the hit path on the freshly filled way
    assign hit_path = (state == s_lookup && hit) || state == s_finish;
    assign touch_en = hit_path;
    assign set_dirty_en = hit_path && write_q;
    assign wr_en = hit_path && write_q;
    assign fill_en = state == s_rf_wait && mem_resp_valid && !mem_resp_error;
    assign fill_way = way_q;
    assign wr_way = fill_en ? way_q : hit_way;

    // read address held steady through a write-back
    always_comb begin
        rd_set = req_a.f.index;
        rd_way = way_q;
        if (fencing) begin
            rd_set = sweep_index;
            rd_way = sweep_way;
        end else if (state == s_lookup) begin
            rd_way = hit ? hit_way : victim_way;
        end
    end

    assign clean_en = state == s_wb_wait && mem_resp_valid && !mem_resp_error;
    assign clean_set = rd_set;
    assign clean_way = rd_way;

    assign mem_req_valid = state == s_wb_req || state == s_rf_req || state == s_uc_req;
    assign mem_req_write = state == s_wb_req || (state == s_uc_req && write_q);
    assign mem_req_single = state == s_uc_req;
    assign mem_wdata = mem_req_single ? {{(line_bits-32){1'b0}}, wr_word_data} : rd_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            fencing <= 1'b0;
            cnt <= '0;
            resp_valid <= 1'b0;
            fence_done <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            fence_done <= 1'b0;
            case (state)
                s_idle: begin
                    cnt <= '0;
                    if (req_valid) begin
                        state <= req_addr[31] ? s_lookup : s_uc_req;
                    end else if (fence) begin
                        state <= s_fence;
                        fencing <= 1'b1;
                    end
                end
                s_lookup: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        state <= s_idle;
                    end else begin
                        state <= victim_dirty ? s_wb_req : s_rf_req;
                    end
                end
                s_wb_req: begin
                    if (mem_req_ready) begin
                        state <= s_wb_wait;
                    end
                end
                s_wb_wait: begin
                    if (mem_resp_valid) begin
                        if (fencing) begin
                            cnt <= cnt + 1'b1;
                            state <= last ? s_idle : s_fence;
                            fencing <= !last;
                            fence_done <= last;
                        end else if (mem_resp_error) begin
                            resp_valid <= 1'b1;
                            state <= s_idle;
                        end else begin
                            state <= s_rf_req;
                        end
                    end
                end
                s_rf_req: begin
                    if (mem_req_ready) begin
                        state <= s_rf_wait;
                    end
                end
                s_rf_wait: begin
                    if (mem_resp_valid) begin
                        resp_valid <= mem_resp_error;
                        state <= mem_resp_error ? s_idle : s_finish;
                    end
                end
                s_finish: begin
                    resp_valid <= 1'b1;
                    state <= s_idle;
                end
                s_uc_req: begin
                    if (mem_req_ready) begin
                        state <= s_uc_wait;
                    end
                end
                s_uc_wait: begin
                    if (mem_resp_valid) begin
                        resp_valid <= 1'b1;
                        state <= s_idle;
                    end
                end
                s_fence: begin
                    if (sweep_dirty) begin
                        state <= s_wb_req;
                    end else begin
                        cnt <= cnt + 1'b1;
                        if (last) begin
                            state <= s_idle;
                            fencing <= 1'b0;
                            fence_done <= 1'b1;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                if (req_valid) begin
                    req_a.raw <= req_addr;
                    write_q <= req_write;
                    wr_strb <= req_wstrb;
                    wr_word_data <= req_wdata;
                    // uncached access goes out as is
                    mem_addr <= req_addr;
                end
            end
            s_lookup: begin
                way_q <= victim_way;
                use_uc <= 1'b0;
                resp_error <= 1'b0;
                mem_addr <= victim_dirty ? line_addr(victim_tag, req_a.f.index)
                                         : line_addr(req_a.f.tag, req_a.f.index);
            end
            s_wb_wait, s_rf_wait: begin
                if (mem_resp_valid) begin
                    resp_error <= mem_resp_error;
                    mem_addr <= line_addr(req_a.f.tag, req_a.f.index);
                end
            end
            s_uc_wait: begin
                if (mem_resp_valid) begin
                    resp_error <= mem_resp_error;
                    uc_data <= mem_resp_data[31:0];
                    use_uc <= 1'b1;
                end
            end
            s_fence: begin
                mem_addr <= line_addr(sweep_tag, sweep_index);
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/cache_data.sv
`timescale 1ns/1ps

module cache_data
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                               clk,
    input  logic [index_bits-1:0]              rd_set,
    input  logic                               rd_way,
    input  logic [$clog2(words_per_line)-1:0]  rd_word,
    input  logic                               wr_en,
    input  logic [index_bits-1:0]              wr_set,
    input  logic                               wr_way,
    input  logic [$clog2(words_per_line)-1:0]  wr_word,
    input  logic [3:0]                         wr_strb,
    input  logic [31:0]                        wr_word_data,
    input  logic                               fill_en,
    input  line_t                              fill_line,
    output logic [31:0]                        rd_word_data,
    output line_t                              rd_line
);

    line_t lines [2*num_sets];
    logic [$clog2(words_per_line)-1:0] rd_word_q;
    logic [index_bits:0] wr_addr;

    assign wr_addr = {wr_set, wr_way};

    // refill wins over a word write
    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[wr_addr] <= fill_line;
        end else if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    lines[wr_addr][wr_word*32 + b*8 +: 8] <= wr_word_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_line <= lines[{rd_set, rd_way}];
        rd_word_q <= rd_word;
    end

    assign rd_word_data = rd_line[rd_word_q*32 +: 32];

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    // geometry of the cached address
    localparam int offset_bits = 4;
    localparam int index_bits = 5;
    localparam int tag_bits = 23;
    localparam int num_sets = 32;

    // bit 31 of raw set means cacheable
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-3:0] word;
            logic [1:0]             byte_sel;
        } f;
    } cache_addr_t;

endpackage

// File: logic/cache_tags.sv
`timescale 1ns/1ps

module cache_tags
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] lookup_index,
    input  logic [tag_bits-1:0]   lookup_tag,
    input  logic                  fill_en,
    input  logic                  fill_way,
    input  logic                  set_dirty_en,
    input  logic                  set_dirty_way,
    input  logic                  clean_en,
    input  logic [index_bits-1:0] clean_set,
    input  logic                  clean_way,
    input  logic                  touch_en,
    input  logic                  touch_way,
    input  logic [index_bits-1:0] sweep_index,
    input  logic                  sweep_way,
    output logic                  hit,
    output logic                  hit_way,
    output logic                  victim_way,
    output logic                  victim_dirty,
    output logic [tag_bits-1:0]   victim_tag,
    output logic                  sweep_dirty,
    output logic [tag_bits-1:0]   sweep_tag
);

    logic [tag_bits-1:0]   tags [2*num_sets];
    logic [2*num_sets-1:0] valid;
    logic [2*num_sets-1:0] dirty;
    // way used last in each set
    logic [num_sets-1:0]   lru;

    logic hit0;
    logic hit1;
    logic v0;
    logic v1;
    logic d0;
    logic d1;

    assign v0 = valid[{lookup_index, 1'b0}];
    assign v1 = valid[{lookup_index, 1'b1}];
    assign d0 = dirty[{lookup_index, 1'b0}];
    assign d1 = dirty[{lookup_index, 1'b1}];

    assign hit0 = v0 && (tags[{lookup_index, 1'b0}] == lookup_tag);
    assign hit1 = v1 && (tags[{lookup_index, 1'b1}] == lookup_tag);
    assign hit = hit0 || hit1;
    assign hit_way = hit1;

    // free way, then the clean one of a mixed pair, then lru
    assign victim_way = (!v0 || !v1) ? v0 : ((d0 ^ d1) ? d0 : !lru[lookup_index]);
    assign victim_dirty = valid[{lookup_index, victim_way}] && dirty[{lookup_index, victim_way}];
    assign victim_tag = tags[{lookup_index, victim_way}];

    assign sweep_dirty = valid[{sweep_index, sweep_way}] && dirty[{sweep_index, sweep_way}];
    assign sweep_tag = tags[{sweep_index, sweep_way}];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[{lookup_index, fill_way}] <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end else begin
            if (fill_en) begin
                valid[{lookup_index, fill_way}] <= 1'b1;
                dirty[{lookup_index, fill_way}] <= 1'b0;
            end
            if (set_dirty_en) begin
                dirty[{lookup_index, set_dirty_way}] <= 1'b1;
            end
            if (clean_en) begin
                dirty[{clean_set, clean_way}] <= 1'b0;
            end
            if (touch_en) begin
                lru[lookup_index] <= touch_way;
            end
        end
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [31:0] req_addr,
    input  logic [3:0]  req_wstrb,
    input  logic [31:0] req_wdata,
    output logic        req_ready,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    output logic        resp_error,
    input  logic        fence,
    output logic        fence_done,
    output logic        mem_req_valid,
    output logic        mem_req_write,
    output logic        mem_req_single,
    output logic [31:0] mem_addr,
    output line_t       mem_wdata,
    input  logic        mem_req_ready,
    input  logic        mem_resp_valid,
    input  line_t       mem_resp_data,
    input  logic        mem_resp_error
);

    logic [index_bits-1:0]  lookup_index;
    logic [tag_bits-1:0]    lookup_tag;
    logic                   fill_en;
    logic                   fill_way;
    logic                   set_dirty_en;
    logic                   clean_en;
    logic [index_bits-1:0]  clean_set;
    logic                   clean_way;
    logic                   touch_en;
    logic [index_bits-1:0]  sweep_index;
    logic                   sweep_way;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [tag_bits-1:0]    victim_tag;
    logic                   sweep_dirty;
    logic [tag_bits-1:0]    sweep_tag;
    logic [index_bits-1:0]  rd_set;
    logic                   rd_way;
    logic [offset_bits-3:0] req_word;
    logic                   wr_en;
    logic                   wr_way;
    logic [3:0]             wr_strb;
    logic [31:0]            wr_word_data;
    logic [31:0]            rd_word_data;
    line_t                  rd_line;

    cache_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wstrb      (req_wstrb),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .resp_error     (resp_error),
        .fence          (fence),
        .fence_done     (fence_done),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .sweep_dirty    (sweep_dirty),
        .sweep_tag      (sweep_tag),
        .lookup_index   (lookup_index),
        .lookup_tag     (lookup_tag),
        .fill_en        (fill_en),
        .fill_way       (fill_way),
        .set_dirty_en   (set_dirty_en),
        .clean_en       (clean_en),
        .clean_set      (clean_set),
        .clean_way      (clean_way),
        .touch_en       (touch_en),
        .sweep_index    (sweep_index),
        .sweep_way      (sweep_way),
        .rd_word_data   (rd_word_data),
        .rd_line        (rd_line),
        .rd_set         (rd_set),
        .rd_way         (rd_way),
        .req_word       (req_word),
        .wr_en          (wr_en),
        .wr_way         (wr_way),
        .wr_strb        (wr_strb),
        .wr_word_data   (wr_word_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_single (mem_req_single),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_error (mem_resp_error)
    );

    // hit-path updates all land on the hit way
    cache_tags tags_i (
        .clk           (clk),
        .rst           (rst),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .set_dirty_en  (set_dirty_en),
        .set_dirty_way (hit_way),
        .clean_en      (clean_en),
        .clean_set     (clean_set),
        .clean_way     (clean_way),
        .touch_en      (touch_en),
        .touch_way     (hit_way),
        .sweep_index   (sweep_index),
        .sweep_way     (sweep_way),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .sweep_dirty   (sweep_dirty),
        .sweep_tag     (sweep_tag)
    );

    cache_data data_i (
        .clk          (clk),
        .rd_set       (rd_set),
        .rd_way       (rd_way),
        .rd_word      (req_word),
        .wr_en        (wr_en),
        .wr_set       (lookup_index),
        .wr_way       (wr_way),
        .wr_word      (req_word),
        .wr_strb      (wr_strb),
        .wr_word_data (wr_word_data),
        .fill_en      (fill_en),
        .fill_line    (mem_resp_data),
        .rd_word_data (rd_word_data),
        .rd_line      (rd_line)
    );

endmodule

// File: logic/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int line_bits = 128;
    localparam int words_per_line = line_bits / 32;

    // one refill or write-back line, word 0 in the low lane
    typedef logic [line_bits-1:0] line_t;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_top -f vlog.f

status=0
./obj_dir/Vtb_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: testbench/cache_assert.sv
`timescale 1ns/1ps

module cache_assert
    import mem_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        fence_done,
    input logic        mem_req_valid,
    input logic        mem_req_ready,
    input logic        mem_req_write,
    input logic        mem_req_single,
    input logic [31:0] mem_addr,
    input line_t       mem_wdata
);

    // a waiting memory request keeps every field
    held_request: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr)
            && $stable(mem_req_write) && $stable(mem_req_single) && $stable(mem_wdata))
        else $error("memory request dropped or changed before it was accepted");

    single_response: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else $error("response valid held for two cycles");

    // busy until the access answers or the sweep ends
    ready_after_done: assert property (@(posedge clk) disable iff (rst)
        $rose(req_ready) |-> resp_valid || fence_done)
        else $error("cache became ready without a response or fence done");

endmodule

bind cache_top cache_assert cache_assert_i (
    .clk            (clk),
    .rst            (rst),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .fence_done     (fence_done),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_single (mem_req_single),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata)
);

// File: testbench/cache_vectors.txt
# op addr strb wdata rdata err mrd mwr, all hex; op 0 read, 1 write, 2 fence
# rdata checked on reads without error; mrd and mwr count memory reads and writes
0 80000104 0 00000000 DA5A0104 0 1 0
0 80000104 0 00000000 DA5A0104 0 0 0
0 8000010C 0 00000000 DA5A010C 0 0 0
1 80000104 5 11223344 00000000 0 0 0
0 80000104 0 00000000 DA220144 0 0 0
# set 3 eviction
1 80000030 F AAAA0001 00000000 0 1 0
1 80000234 F BBBB0002 00000000 0 1 0
0 80000030 0 00000000 AAAA0001 0 0 0
0 80000430 0 00000000 DA5A0430 0 1 1
0 80000234 0 00000000 BBBB0002 0 1 0
0 80000238 0 00000000 DA5A0238 0 0 0
# uncached
0 00000100 0 00000000 5A5A0100 0 1 0
0 00000100 0 00000000 5A5A0100 0 1 0
1 00000100 F CAFE0001 00000000 0 0 1
0 00000100 0 00000000 CAFE0001 0 1 0
# fence
1 80000044 F 44440044 00000000 0 1 0
1 80000058 3 00005858 00000000 0 1 0
2 00000000 0 00000000 00000000 0 0 4
2 00000000 0 00000000 00000000 0 0 0
0 80000244 0 00000000 DA5A0244 0 1 0
0 80000444 0 00000000 DA5A0444 0 1 0
0 80000044 0 00000000 44440044 0 1 0
0 80000058 0 00000000 DA5A5858 0 0 0
# error region
0 F0000010 0 00000000 00000000 1 1 0
0 F0000010 0 00000000 00000000 1 1 0
1 70000020 F 12345678 00000000 1 0 1
0 80000104 0 00000000 DA220144 0 0 0

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import mem_bus_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [3:0]  req_wstrb;
    logic [31:0] req_wdata;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        resp_error;
    logic        fence;
    logic        fence_done;
    logic        mem_req_valid;
    logic        mem_req_write;
    logic        mem_req_single;
    logic [31:0] mem_addr;
    line_t       mem_wdata;
    logic        mem_req_ready;
    logic        mem_resp_valid;
    line_t       mem_resp_data;
    logic        mem_resp_error;

    // one entry per vector line
    logic [1:0]  v_op [$];
    logic [31:0] v_addr [$];
    logic [3:0]  v_strb [$];
    logic [31:0] v_wdata [$];
    logic [31:0] v_rdata [$];
    logic        v_err [$];
    logic [31:0] v_mrd [$];
    logic [31:0] v_mwr [$];

    line_t       mem_lines [logic [31:0]];
    int          mem_reads = 0;
    int          mem_writes = 0;
    logic [31:0] lfsr_state;

    int cycles = 0;
    int cycle_limit = 0;

    tb_clock clock_i (
        .clk (clk)
    );

    cache_top cache_top_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wstrb      (req_wstrb),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .resp_error     (resp_error),
        .fence          (fence),
        .fence_done     (fence_done),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_single (mem_req_single),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_error (mem_resp_error)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic int next_random_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return b ? 1 : 0;
    endfunction

    function automatic int pick_wait();
        int hi;
        int lo;
        hi = next_random_bit();
        lo = next_random_bit();
        return 2 * hi + lo;
    endfunction

    // untouched memory reads back its own address xor a marker
    function automatic line_t line_or_pattern(input logic [31:0] base);
        line_t l;
        if (mem_lines.exists(base)) begin
            l = mem_lines[base];
        end else begin
            for (int w = 0; w < 4; w++) begin
                l[w*32 +: 32] = (base + 32'(w * 4)) ^ 32'h5a5a0000;
            end
        end
        return l;
    endfunction

    task automatic serve_request(input logic [31:0] addr, input logic write,
                                 input logic single, input line_t wdata);
        logic [31:0] base;
        line_t       l;
        int          w;
        base = {addr[31:4], 4'h0};
        w = int'(addr[3:2]);
        mem_resp_data = '0;
        mem_resp_error = 1'b0;
        if (write) begin
            mem_writes++;
        end else begin
            mem_reads++;
        end
        if (addr[30:28] == 3'b111) begin
            mem_resp_error = 1'b1;
        end else if (single) begin
            l = line_or_pattern(base);
            if (write) begin
                l[w*32 +: 32] = wdata[31:0];
                mem_lines[base] = l;
            end else begin
                mem_resp_data[31:0] = l[w*32 +: 32];
            end
        end else if (write) begin
            mem_lines[base] = wdata;
        end else begin
            mem_resp_data = line_or_pattern(base);
        end
        mem_resp_valid = 1'b1;
    endtask

    // memory model answering in order one request at a time
    initial begin : memory_model
        logic [31:0] q_addr;
        logic        q_write;
        logic        q_single;
        line_t       q_wdata;
        int          waits;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        mem_resp_error = 1'b0;
        lfsr_state = 32'd72031;
        forever begin
            @(posedge clk);
            #1;
            mem_resp_valid = 1'b0;
            if (!rst && mem_req_valid) begin
                waits = pick_wait();
                repeat (waits) begin
                    @(posedge clk);
                    #1;
                end
                q_addr = mem_addr;
                q_write = mem_req_write;
                q_single = mem_req_single;
                q_wdata = mem_wdata;
                // one-word access exactly for uncached addresses
                check_val($sformatf("single flag addr %h", q_addr), 32'(!q_addr[31]),
                          32'(q_single));
                mem_req_ready = 1'b1;
                @(posedge clk);
                #1;
                mem_req_ready = 1'b0;
                serve_request(q_addr, q_write, q_single, q_wdata);
            end
        end
    end

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] c_op;
        logic [31:0] c_addr;
        logic [31:0] c_strb;
        logic [31:0] c_wdata;
        logic [31:0] c_rdata;
        logic [31:0] c_err;
        logic [31:0] c_mrd;
        logic [31:0] c_mwr;
        fd = $fopen("testbench/cache_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open testbench/cache_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", c_op, c_addr, c_strb,
                            c_wdata, c_rdata, c_err, c_mrd, c_mwr);
                if (n != 8) begin
                    fail_run($sformatf("malformed vector line %s", line));
                end
                v_op.push_back(c_op[1:0]);
                v_addr.push_back(c_addr);
                v_strb.push_back(c_strb[3:0]);
                v_wdata.push_back(c_wdata);
                v_rdata.push_back(c_rdata);
                v_err.push_back(c_err[0]);
                v_mrd.push_back(c_mrd);
                v_mwr.push_back(c_mwr);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_access(input int i);
        string name;
        int    reads_before;
        int    writes_before;
        int    lat;
        logic  taken;
        name = $sformatf("vector %0d addr %h", i, v_addr[i]);
        reads_before = mem_reads;
        writes_before = mem_writes;
        req_valid = 1'b1;
        req_write = (v_op[i] == 2'd1);
        req_addr = v_addr[i];
        req_wstrb = v_strb[i];
        req_wdata = v_wdata[i];
        taken = 1'b0;
        while (!taken) begin
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!resp_valid);
        check_val({name, " error"}, 32'(v_err[i]), 32'(resp_error));
        if (v_op[i] == 2'd0 && !v_err[i]) begin
            check_val({name, " read data"}, v_rdata[i], resp_rdata);
        end
        check_val({name, " memory reads"}, v_mrd[i], 32'(mem_reads - reads_before));
        check_val({name, " memory writes"}, v_mwr[i], 32'(mem_writes - writes_before));
        // a cached hit answers on the edge after the transfer
        if (v_addr[i][31] && v_mrd[i] == 0 && v_mwr[i] == 0) begin
            check_val({name, " hit latency"}, 32'd1, 32'(lat));
        end
    endtask

    task automatic run_fence(input int i);
        string name;
        int    reads_before;
        int    writes_before;
        logic  taken;
        name = $sformatf("vector %0d fence", i);
        reads_before = mem_reads;
        writes_before = mem_writes;
        fence = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        fence = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!fence_done);
        check_val({name, " memory reads"}, v_mrd[i], 32'(mem_reads - reads_before));
        check_val({name, " write-backs"}, v_mwr[i], 32'(mem_writes - writes_before));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles without finishing", cycles));
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        fence = 1'b0;
        read_vectors();
        cycle_limit = 16 + 200 * v_op.size();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < v_op.size(); i++) begin
            if (v_op[i] == 2'd2) begin
                run_fence(i);
            end else begin
                run_access(i);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: vlog.f
logic/cache_pkg.sv
logic/mem_bus_pkg.sv
logic/cache_tags.sv
logic/cache_data.sv
logic/cache_ctrl.sv
logic/cache_top.sv
testbench/tb_clock.sv
testbench/cache_assert.sv
testbench/tb_top.sv
